// File: all.f
logic/dma_pkg.sv
logic/dma_csr.sv
logic/dma_copy_engine.sv
logic/dma_pcie_bridge.sv
logic/dma_subsystem.sv
test/dma_pcie_bridge_properties.sv
test/dma_tb.sv

// File: Makefile
# Verilator build and run of the DMA subsystem testbench.
TOP = dma_tb

.PHONY: all compile run clean

all: run

compile:
	verilator --binary --timing --assert -Wno-fatal --top-module $(TOP) -f all.f -o $(TOP)

run: compile
	./obj_dir/$(TOP) > sim.log 2>&1 || true
	cat sim.log
	@if grep -q "TEST FAILED" sim.log; then echo "Simulation failed"; exit 1; fi
	@grep -q "TEST OK" sim.log || (echo "Simulation ended without a result"; exit 1)

clean:
	rm -rf obj_dir sim.log

// File: test/dma_tb.sv
`timescale 1ns/1ns

module dma_tb;
   import dma_pkg::*;

   localparam int          clk_period = 40;
   localparam int          mem_words = 2048;  // Narrow 64-bit words.
   localparam int          max_burst = 16;
   localparam logic [31:0] addr_offset = 32'h0000_1000;
   localparam logic [31:0] seed = 32'd50771;
   localparam int          total_words = 1 + 37 + 37 + 0;  // All copy lengths.
   localparam int          poll_limit = 2000;

   logic         clk;
   logic         reset;
   logic [1:0]   csr_address;
   logic         csr_write;
   logic [31:0]  csr_writedata;
   logic         csr_read;
   logic [31:0]  csr_readdata;
   logic [31:0]  pcie_address;
   logic         pcie_read;
   logic [63:0]  pcie_readdata;
   logic         pcie_readdatavalid;
   logic         pcie_write;
   logic [63:0]  pcie_writedata;
   logic [9:0]   pcie_burstcount;
   logic [7:0]   pcie_byteenable;
   logic         pcie_waitrequest;

   logic [63:0]  mem [mem_words];
   logic [63:0]  shadow [mem_words];  // Expected memory.
   logic [31:0]  fill_state;
   logic [31:0]  model_state;
   int           errors;
   bit           heavy;  // Back-pressure mode.

   bit           log_is_write [$];  // Narrow bursts seen by the memory.
   logic [31:0]  log_addr [$];
   int           log_count [$];
   int           rd_pending_word [$];
   int           rd_pending_count [$];

   dma_subsystem
   #(
      .addr_offset (addr_offset)
   )
   dut (.*);

   bind dma_pcie_bridge dma_pcie_bridge_properties
   #(
      .pcie_width  (pcie_width),
      .width_ratio (dma_width / pcie_width)
   )
   u_props
   (
      .clk                (clk),
      .reset              (reset),
      .pcie_address       (pcie_address),
      .pcie_read          (pcie_read),
      .pcie_write         (pcie_write),
      .pcie_writedata     (pcie_writedata),
      .pcie_readdatavalid (pcie_readdatavalid),
      .pcie_waitrequest   (pcie_waitrequest),
      .dma_readdatavalid  (dma_readdatavalid)
   );

   function automatic logic [31:0] xorshift(input logic [31:0] x);
      logic [31:0] y;
      y = x ^ (x << 13);
      y = y ^ (y >> 17);
      return y ^ (y << 5);
   endfunction

   // First narrow word of a wide index.
   function automatic int word_of(input int index);
      return int'(addr_offset >> 3) + index * 4;
   endfunction

   function automatic void reference_copy(input int src, input int dst, input int len);
      for (int i = 0; i < len * 4; i++)
         shadow[word_of(dst) + i] = shadow[word_of(src) + i];
   endfunction

   task automatic check_value(input string name, input logic [63:0] expected,
                              input logic [63:0] actual);
      if (actual !== expected)
      begin
         $display("MISMATCH %s expected %h actual %h", name, expected, actual);
         errors++;
      end
   endtask

   task automatic fill_memory();
      for (int i = 0; i < mem_words; i++)
      begin
         fill_state = xorshift(fill_state);
         mem[i][31:0] = fill_state;
         fill_state = xorshift(fill_state);
         mem[i][63:32] = fill_state ^ 32'(i);  // Address in every word.
         shadow[i] = mem[i];
      end
   endtask

   task automatic record_request(input bit is_write, input logic [31:0] addr,
                                 input logic [9:0] count);
      log_is_write.push_back(is_write);
      log_addr.push_back(addr);
      log_count.push_back(int'(count));
   endtask

   // ****************************************
   // Clock and watchdog
   // ****************************************
   initial
   begin
      clk = 1'b0;
      forever
         #(clk_period / 2) clk = ~clk;
   end

   initial
   begin
      #(total_words * 40 * clk_period);
      $display("Watchdog expired after %0d ns, a copy never finished",
               total_words * 40 * clk_period);
      $display("errors: %0d", errors + 1);
      $display("TEST FAILED");
      $finish;
   end

   // ****************************************
   // Host memory on the PCIe side
   // ****************************************
   initial
   begin : host_memory
      int wr_base;
      int wr_len;
      int wr_beat;
      int rd_word;
      int rd_left;
      int rd_delay;
      wr_base = 0;
      wr_len = 0;
      wr_beat = 0;
      rd_word = 0;
      rd_left = 0;
      rd_delay = 0;
      forever
      begin
         @(posedge clk);
         if (!reset && pcie_read && !pcie_waitrequest)
         begin
            record_request(1'b0, pcie_address, pcie_burstcount);
            rd_pending_word.push_back(int'(pcie_address >> 3));
            rd_pending_count.push_back(int'(pcie_burstcount));
         end
         if (!reset && pcie_write && !pcie_waitrequest)
         begin
            if (wr_beat == 0)
            begin
               record_request(1'b1, pcie_address, pcie_burstcount);
               wr_base = int'(pcie_address >> 3);
               wr_len = int'(pcie_burstcount);
            end
            check_value("write byteenable", 64'hff, 64'(pcie_byteenable));
            if (wr_base + wr_beat < mem_words)
               mem[wr_base + wr_beat] = pcie_writedata;
            else
            begin
               $display("Write to narrow word %0d is outside host memory", wr_base + wr_beat);
               errors++;
            end
            wr_beat++;
            if (wr_beat >= wr_len)
               wr_beat = 0;  // Burst complete.
         end
         #1;
         model_state = xorshift(model_state);
         pcie_waitrequest = heavy ? (model_state[1:0] < 2'd2) : (model_state[2:0] == 3'd0);
         pcie_readdatavalid = 1'b0;
         if (rd_left == 0 && rd_pending_word.size() > 0)
         begin
            rd_word = rd_pending_word.pop_front();
            rd_left = rd_pending_count.pop_front();
            rd_delay = heavy ? 3 + int'(model_state[18:16]) % 4 : 1 + int'(model_state[18:16]) % 3;
         end
         if (rd_left > 0)
         begin
            if (rd_delay > 0)
               rd_delay--;
            else if (!(heavy && model_state[12]))
            begin
               pcie_readdatavalid = 1'b1;
               if (rd_word < mem_words)
                  pcie_readdata = mem[rd_word];
               else
               begin
                  $display("Read from narrow word %0d is outside host memory", rd_word);
                  errors++;
                  pcie_readdata = '0;
               end
               rd_word++;
               rd_left--;
            end
         end
      end
   end

   // ****************************************
   // Register access and copies
   // ****************************************
   task automatic next_cycle();
      @(posedge clk);
      #1;
   endtask

   task automatic csr_store(input logic [1:0] addr, input logic [31:0] data);
      csr_address = addr;
      csr_writedata = data;
      csr_write = 1'b1;
      next_cycle();
      csr_write = 1'b0;
   endtask

   task automatic csr_load(input logic [1:0] addr, output logic [31:0] data);
      csr_address = addr;
      csr_read = 1'b1;
      next_cycle();
      csr_read = 1'b0;
      data = csr_readdata;  // Registered one cycle after the strobe.
   endtask

   // Expected narrow bursts: read the source, then write the destination, per round.
   task automatic check_requests(input string name, input int src, input int dst, input int len);
      int left;
      int chunk;
      int n;
      int idx;
      left = len;
      n = 0;
      while (left > 0)
      begin
         chunk = (left > max_burst) ? max_burst : left;
         for (int k = 0; k < 2; k++)
         begin
            idx = (k == 0) ? src : dst;
            if (n < log_addr.size())
            begin
               check_value({name, " request kind"}, 64'(k), 64'(log_is_write[n]));
               check_value({name, " address"}, 64'(addr_offset + 32'(idx * 32)),
                           64'(log_addr[n]));
               check_value({name, " burstcount"}, 64'(chunk * 4), 64'(log_count[n]));
            end
            n++;
         end
         src += chunk;
         dst += chunk;
         left -= chunk;
      end
      check_value({name, " request count"}, 64'(n), 64'(log_addr.size()));
   endtask

   task automatic run_copy(input string name, input int src, input int dst, input int len);
      dma_ctrl_word_u word;
      int polls;
      log_is_write.delete();
      log_addr.delete();
      log_count.delete();
      reference_copy(src, dst, len);
      csr_store(csr_src, 32'(src));
      csr_store(csr_dst, 32'(dst));
      csr_store(csr_len, 32'(len));
      word = '0;
      word.ctrl.start = 1'b1;
      csr_store(csr_ctrl, word);
      word = '0;
      polls = 0;
      while (!word.status.done && polls < poll_limit)
      begin
         csr_load(csr_ctrl, word);
         polls++;
      end
      if (!word.status.done)
      begin
         $display("%s: done was not set after %0d status reads", name, polls);
         errors++;
      end
      check_value({name, " busy after done"}, 64'd0, 64'(word.status.busy));
      for (int i = 0; i < mem_words; i++)
         check_value($sformatf("%s word %0d", name, i), shadow[i], mem[i]);
      check_requests(name, src, dst, len);
      word = '0;
      word.ctrl.clear_done = 1'b1;
      csr_store(csr_ctrl, word);
   endtask

   initial
   begin : main
      logic [31:0] value;
      reset = 1'b1;
      csr_address = '0;
      csr_write = 1'b0;
      csr_writedata = '0;
      csr_read = 1'b0;
      pcie_readdata = '0;
      pcie_readdatavalid = 1'b0;
      pcie_waitrequest = 1'b0;
      errors = 0;
      heavy = 1'b0;
      fill_state = seed;
      model_state = seed;
      fill_memory();
      repeat (4) @(posedge clk);
      #1;
      reset = 1'b0;

      csr_load(csr_ctrl, value);
      check_value("status after reset", 64'd0, 64'(value));
      csr_store(csr_src, 32'd5);
      csr_store(csr_dst, 32'd77);
      csr_store(csr_len, 32'd9);
      csr_load(csr_src, value);
      check_value("src readback", 64'd5, 64'(value));
      csr_load(csr_dst, value);
      check_value("dst readback", 64'd77, 64'(value));
      csr_load(csr_len, value);
      check_value("len readback", 64'd9, 64'(value));

      run_copy("single word", 3, 200, 1);
      fill_memory();
      run_copy("copy 37", 10, 100, 37);
      fill_memory();
      heavy = 1'b1;
      run_copy("back-pressure", 10, 100, 37);
      heavy = 1'b0;
      run_copy("zero length", 20, 300, 0);

      errors += dut.u_bridge.u_props.failures;
      $display("errors: %0d", errors);
      if (errors == 0)
         $display("TEST OK");
      else
         $display("TEST FAILED");
      $finish;
   end

endmodule

// File: test/dma_pcie_bridge_properties.sv
`timescale 1ns/1ns

module dma_pcie_bridge_properties
#(
   parameter int pcie_width = 64,
   parameter int width_ratio = 4
)
(
   input logic                   clk,
   input logic                   reset,
   input logic [31:0]            pcie_address,
   input logic                   pcie_read,
   input logic                   pcie_write,
   input logic [pcie_width-1:0]  pcie_writedata,
   input logic                   pcie_readdatavalid,
   input logic                   pcie_waitrequest,
   input logic                   dma_readdatavalid
);

   localparam int count_width = $clog2(width_ratio);

   int                      failures = 0;  // Read back by the testbench.
   logic [count_width-1:0]  narrow_count;   // Narrow read words seen so far.

   always_ff @(posedge clk or posedge reset)
   begin
      if (reset)
         narrow_count <= '0;
      else if (pcie_readdatavalid)
         narrow_count <= narrow_count + 1'b1;
   end

   // ****************************************
   // PCIe side rules
   // ****************************************
   read_write_exclusive: assert property (@(posedge clk) disable iff (reset)
      !(pcie_read && pcie_write))
   else
   begin
      $error("pcie_read and pcie_write are high in the same cycle");
      failures++;
   end

   // A stalled write beat keeps its address and data.
   write_held_stable: assert property (@(posedge clk) disable iff (reset)
      (pcie_write && pcie_waitrequest) |=> ($stable(pcie_address) && $stable(pcie_writedata)))
   else
   begin
      $error("pcie_address or pcie_writedata changed while the write was stalled");
      failures++;
   end

   // A wide word completes with the last narrow word of each group, and only then.
   wide_valid_on_last_narrow: assert property (@(posedge clk) disable iff (reset)
      dma_readdatavalid ==
         (pcie_readdatavalid && (narrow_count == count_width'(width_ratio - 1))))
   else
   begin
      $error("dma_readdatavalid does not match the last narrow word of a group");
      failures++;
   end

endmodule

// File: logic/dma_subsystem.sv
`timescale 1ns/1ns

module dma_subsystem
#(
   parameter int          dma_width = 256,
   parameter int          pcie_width = 64,
   parameter int          dma_burstcount_width = 6,
   parameter int          pcie_burstcount_width = 10,
   parameter int          pcie_addr_width = 30,
   parameter logic [31:0] addr_offset = 32'd0,
   parameter int          max_burst = 16
)
(
   input  logic                              clk,
   input  logic                              reset,
   input  logic [1:0]                        csr_address,
   input  logic                              csr_write,
   input  logic [31:0]                       csr_writedata,
   input  logic                              csr_read,
   output logic [31:0]                       csr_readdata,
   output logic [31:0]                       pcie_address,
   output logic                              pcie_read,
   input  logic [pcie_width-1:0]             pcie_readdata,
   input  logic                              pcie_readdatavalid,
   output logic                              pcie_write,
   output logic [pcie_width-1:0]             pcie_writedata,
   output logic [pcie_burstcount_width-1:0]  pcie_burstcount,
   output logic [pcie_width/8-1:0]           pcie_byteenable,
   input  logic                              pcie_waitrequest
);
   import dma_pkg::*;

   localparam int dma_addr_width = pcie_addr_width - $clog2(dma_width / 8);

   // Register block to engine.
   logic [dma_addr_width-1:0]  src_index;
   logic [dma_addr_width-1:0]  dst_index;
   logic [len_width-1:0]       length;
   logic                       start;
   logic                       busy;
   logic                       done_pulse;

   // Engine to bridge, wide side.
   logic [dma_addr_width-1:0]        dma_address;
   logic                             dma_read;
   logic [dma_width-1:0]             dma_readdata;
   logic                             dma_readdatavalid;
   logic                             dma_write;
   logic [dma_width-1:0]             dma_writedata;
   logic [dma_burstcount_width-1:0]  dma_burstcount;
   logic [dma_width/8-1:0]           dma_byteenable;
   logic                             dma_waitrequest;

   dma_csr
   #(
      .addr_width (dma_addr_width)
   )
   u_csr
   (
      .clk           (clk),
      .reset         (reset),
      .csr_address   (csr_address),
      .csr_write     (csr_write),
      .csr_writedata (csr_writedata),
      .csr_read      (csr_read),
      .csr_readdata  (csr_readdata),
      .busy          (busy),
      .done_pulse    (done_pulse),
      .src_index     (src_index),
      .dst_index     (dst_index),
      .length        (length),
      .start         (start)
   );

   dma_copy_engine
   #(
      .dma_width   (dma_width),
      .addr_width  (dma_addr_width),
      .burst_width (dma_burstcount_width),
      .max_burst   (max_burst)
   )
   u_engine
   (
      .clk               (clk),
      .reset             (reset),
      .src_index         (src_index),
      .dst_index         (dst_index),
      .length            (length),
      .start             (start),
      .busy              (busy),
      .done_pulse        (done_pulse),
      .dma_address       (dma_address),
      .dma_read          (dma_read),
      .dma_write         (dma_write),
      .dma_writedata     (dma_writedata),
      .dma_burstcount    (dma_burstcount),
      .dma_byteenable    (dma_byteenable),
      .dma_readdata      (dma_readdata),
      .dma_readdatavalid (dma_readdatavalid),
      .dma_waitrequest   (dma_waitrequest)
   );

   dma_pcie_bridge
   #(
      .dma_width             (dma_width),
      .pcie_width            (pcie_width),
      .dma_burstcount_width  (dma_burstcount_width),
      .pcie_burstcount_width (pcie_burstcount_width),
      .pcie_addr_width       (pcie_addr_width),
      .addr_offset           (addr_offset)
   )
   u_bridge
   (
      .clk                (clk),
      .reset              (reset),
      .dma_address        (dma_address),
      .dma_read           (dma_read),
      .dma_readdata       (dma_readdata),
      .dma_readdatavalid  (dma_readdatavalid),
      .dma_write          (dma_write),
      .dma_writedata      (dma_writedata),
      .dma_burstcount     (dma_burstcount),
      .dma_byteenable     (dma_byteenable),
      .dma_waitrequest    (dma_waitrequest),
      .pcie_address       (pcie_address),
      .pcie_read          (pcie_read),
      .pcie_readdata      (pcie_readdata),
      .pcie_readdatavalid (pcie_readdatavalid),
      .pcie_write         (pcie_write),
      .pcie_writedata     (pcie_writedata),
      .pcie_burstcount    (pcie_burstcount),
      .pcie_byteenable    (pcie_byteenable),
      .pcie_waitrequest   (pcie_waitrequest)
   );

endmodule

// File: logic/dma_pcie_bridge.sv
`timescale 1ns/1ns

module dma_pcie_bridge
#(
   parameter int          dma_width = 256,
   parameter int          pcie_width = 64,
   parameter int          dma_burstcount_width = 6,
   parameter int          pcie_burstcount_width = 10,
   parameter int          pcie_addr_width = 30,
   parameter logic [31:0] addr_offset = 32'd0,
   localparam int         dma_width_bytes = dma_width / 8,
   localparam int         pcie_width_bytes = pcie_width / 8,
   localparam int         dma_addr_width = pcie_addr_width - $clog2(dma_width_bytes)
)
(
   input  logic                              clk,
   input  logic                              reset,
   input  logic [dma_addr_width-1:0]         dma_address,
   input  logic                              dma_read,
   output logic [dma_width-1:0]              dma_readdata,
   output logic                              dma_readdatavalid,
   input  logic                              dma_write,
   input  logic [dma_width-1:0]              dma_writedata,
   input  logic [dma_burstcount_width-1:0]   dma_burstcount,
   input  logic [dma_width_bytes-1:0]        dma_byteenable,
   output logic                              dma_waitrequest,
   output logic [31:0]                       pcie_address,
   output logic                              pcie_read,
   input  logic [pcie_width-1:0]             pcie_readdata,
   input  logic                              pcie_readdatavalid,
   output logic                              pcie_write,
   output logic [pcie_width-1:0]             pcie_writedata,
   output logic [pcie_burstcount_width-1:0]  pcie_burstcount,
   output logic [pcie_width_bytes-1:0]       pcie_byteenable,
   input  logic                              pcie_waitrequest
);
   localparam int width_ratio = dma_width / pcie_width;
   localparam int addr_shift = $clog2(width_ratio);
   localparam int pack_width = dma_width - pcie_width;

   logic [31:0] dma_byte_address;

   assign dma_byte_address = 32'(dma_address) << $clog2(dma_width_bytes);

   // ****************************************
   // Read path: pack narrow words
   // ****************************************
   logic [addr_shift-1:0]  r_wc;
   logic [pack_width-1:0]  r_buffer;
   logic                   r_full;

   assign r_full = &r_wc;

   always_ff @(posedge clk or posedge reset)
   begin
      if (reset)
         r_wc <= '0;
      else if (pcie_readdatavalid)
         r_wc <= r_wc + 1'b1;
   end

   // Newest word enters at the top, so the oldest ends lowest.
   always_ff @(posedge clk)
   begin
      if (pcie_readdatavalid && !r_full)
         r_buffer <= {pcie_readdata, r_buffer[pack_width-1:pcie_width]};
   end

   assign dma_readdata = {pcie_readdata, r_buffer};
   assign dma_readdatavalid = r_full && pcie_readdatavalid;

   // ****************************************
   // Write path: serialize wide words
   // ****************************************
   logic [addr_shift-1:0]        w_wc;
   logic [pcie_width-1:0]        w_writedata;
   logic [pcie_width_bytes-1:0]  w_byteenable;
   logic                         w_sent;
   logic                         w_hold;

   assign w_sent = pcie_write && !pcie_waitrequest;
   assign w_writedata = dma_writedata[w_wc*pcie_width +: pcie_width];
   assign w_byteenable = dma_byteenable[w_wc*pcie_width_bytes +: pcie_width_bytes];
   assign w_hold = pcie_write && !(&w_wc);  // Stall until the last lane goes out.

   always_ff @(posedge clk or posedge reset)
   begin
      if (reset)
         w_wc <= '0;
      else if (w_sent)
         w_wc <= w_wc + 1'b1;
   end

   assign pcie_address = addr_offset + dma_byte_address;
   assign pcie_read = dma_read;
   assign pcie_write = dma_write;
   assign pcie_writedata = w_writedata;
   assign pcie_burstcount = pcie_burstcount_width'(dma_burstcount) << addr_shift;
   assign pcie_byteenable = pcie_write ? w_byteenable : '1;
   assign dma_waitrequest = pcie_waitrequest || w_hold;

endmodule

// File: logic/dma_copy_engine.sv
`timescale 1ns/1ns

module dma_copy_engine
#(
   parameter int dma_width = 256,
   parameter int addr_width = 25,
   parameter int burst_width = 6,
   parameter int max_burst = 16
)
(
   input  logic                           clk,
   input  logic                           reset,
   input  logic [addr_width-1:0]          src_index,
   input  logic [addr_width-1:0]          dst_index,
   input  logic [dma_pkg::len_width-1:0]  length,
   input  logic                           start,
   output logic                           busy,
   output logic                           done_pulse,
   output logic [addr_width-1:0]          dma_address,
   output logic                           dma_read,
   output logic                           dma_write,
   output logic [dma_width-1:0]           dma_writedata,
   output logic [burst_width-1:0]         dma_burstcount,
   output logic [dma_width/8-1:0]         dma_byteenable,
   input  logic [dma_width-1:0]           dma_readdata,
   input  logic                           dma_readdatavalid,
   input  logic                           dma_waitrequest
);
   import dma_pkg::*;

   localparam int idx_width = $clog2(max_burst);
   localparam int cnt_width = $clog2(max_burst + 1);

   typedef enum logic [2:0]
   {
      st_idle,
      st_read_req,
      st_read_collect,
      st_write,
      st_finish
   } state_t;

   state_t                 state;
   logic [addr_width-1:0]  src_ptr;
   logic [addr_width-1:0]  dst_ptr;
   logic [len_width-1:0]   remaining;
   logic [len_width-1:0]   rem_next;
   logic [cnt_width-1:0]   chunk;
   logic [cnt_width-1:0]   last_idx;
   logic [idx_width-1:0]   rd_count;
   logic [idx_width-1:0]   wr_count;
   logic                   read_last;
   logic                   write_last;
   logic [dma_width-1:0]   buffer [max_burst];

   // Words moved in one round.
   function automatic logic [cnt_width-1:0] round_size(input logic [len_width-1:0] n);
      if (n > len_width'(max_burst))
         return cnt_width'(max_burst);
      return n[cnt_width-1:0];
   endfunction

   assign last_idx = chunk - 1'b1;
   assign rem_next = remaining - len_width'(chunk);
   assign read_last = dma_readdatavalid && (rd_count == last_idx[idx_width-1:0]);
   assign write_last = (state == st_write) && !dma_waitrequest &&
                       (wr_count == last_idx[idx_width-1:0]);

   // ****************************************
   // Sequencer
   // ****************************************
   always_ff @(posedge clk or posedge reset)
   begin
      if (reset)
      begin
         state <= st_idle;
         src_ptr <= '0;
         dst_ptr <= '0;
         remaining <= '0;
         chunk <= '0;
         rd_count <= '0;
         wr_count <= '0;
      end
      else
      begin
         case (state)
            st_idle:
            begin
               if (start)
               begin
                  src_ptr <= src_index;
                  dst_ptr <= dst_index;
                  remaining <= length;
                  chunk <= round_size(length);
                  rd_count <= '0;
                  state <= (length == '0) ? st_finish : st_read_req;
               end
            end
            st_read_req:
            begin
               if (dma_readdatavalid)
                  rd_count <= rd_count + 1'b1;
               if (!dma_waitrequest)
                  state <= st_read_collect;
            end
            st_read_collect:
            begin
               if (dma_readdatavalid)
                  rd_count <= rd_count + 1'b1;
               if (read_last)
               begin
                  wr_count <= '0;
                  state <= st_write;  // Whole burst is buffered.
               end
            end
            st_write:
            begin
               if (!dma_waitrequest)
                  wr_count <= wr_count + 1'b1;
               if (write_last)
               begin
                  src_ptr <= src_ptr + addr_width'(chunk);
                  dst_ptr <= dst_ptr + addr_width'(chunk);
                  remaining <= rem_next;
                  chunk <= round_size(rem_next);
                  rd_count <= '0;
                  state <= (rem_next == '0) ? st_idle : st_read_req;
               end
            end
            default:
               state <= st_idle;  // Zero-length copy ends here.
         endcase
      end
   end

   // Buffer fills in arrival order.
   always_ff @(posedge clk)
   begin
      if (dma_readdatavalid && ((state == st_read_req) || (state == st_read_collect)))
         buffer[rd_count] <= dma_readdata;
   end

   assign busy = (state != st_idle);
   assign done_pulse = (state == st_finish) || (write_last && (rem_next == '0));

   assign dma_read = (state == st_read_req);
   assign dma_write = (state == st_write);
   assign dma_address = (state == st_write) ? dst_ptr : src_ptr;  // Held for the burst.
   assign dma_burstcount = burst_width'(chunk);
   assign dma_writedata = buffer[wr_count];
   assign dma_byteenable = '1;  // Whole words only.

endmodule

// File: logic/dma_csr.sv
`timescale 1ns/1ns

module dma_csr
#(
   parameter int addr_width = 25
)
(
   input  logic                           clk,
   input  logic                           reset,
   input  logic [1:0]                     csr_address,
   input  logic                           csr_write,
   input  logic [31:0]                    csr_writedata,
   input  logic                           csr_read,
   output logic [31:0]                    csr_readdata,
   input  logic                           busy,
   input  logic                           done_pulse,
   output logic [addr_width-1:0]          src_index,
   output logic [addr_width-1:0]          dst_index,
   output logic [dma_pkg::len_width-1:0]  length,
   output logic                           start
);
   import dma_pkg::*;

   dma_ctrl_word_u wr_word;
   dma_ctrl_word_u rd_word;
   logic           done;
   logic           ctrl_write;
   logic           start_req;
   logic           clear_req;

   assign wr_word = csr_writedata;
   assign ctrl_write = csr_write && (csr_address == csr_ctrl);
   assign start_req = ctrl_write && wr_word.ctrl.start && !busy && !start;  // One launch only.
   assign clear_req = ctrl_write && wr_word.ctrl.clear_done;

   always_comb
   begin
      rd_word = '0;
      rd_word.status.busy = busy;
      rd_word.status.done = done;
   end

   // ****************************************
   // Register writes
   // ****************************************
   always_ff @(posedge clk or posedge reset)
   begin
      if (reset)
      begin
         src_index <= '0;
         dst_index <= '0;
         length <= '0;
         done <= 1'b0;
         start <= 1'b0;
      end
      else
      begin
         start <= start_req;
         if (csr_write && (csr_address == csr_src))
            src_index <= csr_writedata[addr_width-1:0];
         if (csr_write && (csr_address == csr_dst))
            dst_index <= csr_writedata[addr_width-1:0];
         if (csr_write && (csr_address == csr_len))
            length <= csr_writedata[len_width-1:0];
         if (done_pulse)
            done <= 1'b1;  // Completion wins over a clear.
         else if (start_req || clear_req)
            done <= 1'b0;
      end
   end

   // Read data is valid the cycle after csr_read.
   always_ff @(posedge clk)
   begin
      if (csr_read)
      begin
         case (csr_address)
            csr_src:  csr_readdata <= 32'(src_index);
            csr_dst:  csr_readdata <= 32'(dst_index);
            csr_len:  csr_readdata <= 32'(length);
            default:  csr_readdata <= rd_word;
         endcase
      end
   end

endmodule

// File: logic/dma_pkg.sv
package dma_pkg;

   // ****************************************
   // Register map
   // ****************************************
   localparam logic [1:0] csr_src = 2'd0;   // Source wide-word index.
   localparam logic [1:0] csr_dst = 2'd1;   // Destination wide-word index.
   localparam logic [1:0] csr_len = 2'd2;   // Length in wide words.
   localparam logic [1:0] csr_ctrl = 2'd3;  // Control on write, status on read.

   localparam int len_width = 16;  // Length registers and counters.

   // ****************************************
   // Control/status word
   // ****************************************
   typedef struct packed
   {
      logic [29:0] reserved;
      logic        clear_done;  // Drops the done flag.
      logic        start;       // Launches a copy when idle.
   } dma_ctrl_view_s;

   typedef struct packed
   {
      logic [29:0] reserved;
      logic        done;  // Set by the engine, held until cleared.
      logic        busy;  // Engine is moving data.
   } dma_status_view_s;

   // Same 32-bit word, seen as control when written and as status when read.
   typedef union packed
   {
      dma_ctrl_view_s   ctrl;
      dma_status_view_s status;
   } dma_ctrl_word_u;

endpackage
